// File: hw/cgra_pkg.sv
/*
  Shared widths, instruction fields and encodings of the CGRA.
  Source code 7 in an operand field is reserved and reads as zero.
*/
`default_nettype none

package cgra_pkg;

  // ----------------------------------------
  // Data path
  // ----------------------------------------
  localparam int DP_WIDTH = 32;
  typedef logic [DP_WIDTH-1:0] word_t;

  // ----------------------------------------
  // Instruction word
  // ----------------------------------------
  localparam int INSTR_WIDTH = 32;
  typedef logic [INSTR_WIDTH-1:0] instr_t;

  // Field positions inside instr_t
  localparam int OPC_LSB   = 28;
  localparam int OPC_WIDTH = 4;
  localparam int SRCA_LSB  = 25;
  localparam int SRCB_LSB  = 22;
  localparam int SRC_WIDTH = 3;
  localparam int IMM_WIDTH = 16;

  // Unknown codes decode as a no-op
  typedef enum logic [OPC_WIDTH-1:0] {
    OP_NOP   = 4'h0,
    OP_ADD   = 4'h1,
    OP_SUB   = 4'h2,
    OP_AND   = 4'h3,
    OP_XOR   = 4'h4,
    OP_LOAD  = 4'h5,
    OP_STORE = 4'h6,
    OP_EXIT  = 4'h7
  } opcode_e;

  // Operand sources, neighbours follow the torus
  typedef enum logic [SRC_WIDTH-1:0] {
    SRC_OWN    = 3'd0,
    SRC_LEFT   = 3'd1,
    SRC_RIGHT  = 3'd2,
    SRC_TOP    = 3'd3,
    SRC_BOTTOM = 3'd4,
    SRC_IMM    = 3'd5,
    SRC_ZERO   = 3'd6
  } src_e;

  // ----------------------------------------
  // Column sequencer
  // ----------------------------------------
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_RUN  = 2'd1,
    ST_WAIT = 2'd2
  } seq_state_e;

  // Default array geometry
  localparam int DEF_N_ROW    = 4;
  localparam int DEF_N_COL    = 4;
  localparam int DEF_NUM_CREG = 16;

endpackage

`default_nettype wire

// File: hw/rc_cell.sv
/*
  One reconfigurable cell. The configuration memory has no reset and
  must be written before the column is started.
*/
`timescale 1ns/1ns
`default_nettype none

module rc_cell
  import cgra_pkg::*;
#(
  parameter int NUM_CREG = DEF_NUM_CREG
) (
  input  wire logic                        clk_i,
  input  wire logic                        conf_we_i,
  input  wire logic [$clog2(NUM_CREG)-1:0] conf_addr_i,
  input  wire instr_t                      conf_word_i,
  input  wire logic [$clog2(NUM_CREG)-1:0] pc_i,
  input  wire word_t                       own_i,
  input  wire word_t                       left_i,
  input  wire word_t                       right_i,
  input  wire word_t                       top_i,
  input  wire word_t                       bottom_i,
  output word_t                            result_o,
  output logic                             load_o,
  output logic                             store_o,
  output logic                             exit_o,
  output word_t                            mem_add_o,
  output word_t                            mem_wdata_o
);

  instr_t  cmem [NUM_CREG];
  instr_t  instr;
  opcode_e opcode;
  src_e    src_a;
  src_e    src_b;
  word_t   imm;
  word_t   op_a;
  word_t   op_b;

  function automatic word_t pick_operand(
    input src_e  sel,
    input word_t own,
    input word_t left,
    input word_t right,
    input word_t top,
    input word_t bottom,
    input word_t imm_val
  );
    word_t val;
    case (sel)
      SRC_OWN:    val = own;
      SRC_LEFT:   val = left;
      SRC_RIGHT:  val = right;
      SRC_TOP:    val = top;
      SRC_BOTTOM: val = bottom;
      SRC_IMM:    val = imm_val;
      default:    val = '0;
    endcase
    return val;
  endfunction

  // ----------------------------------------
  // Configuration memory
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (conf_we_i) begin
      cmem[conf_addr_i] <= conf_word_i;
    end
  end

  assign instr  = cmem[pc_i];
  assign opcode = opcode_e'(instr[OPC_LSB +: OPC_WIDTH]);
  assign src_a  = src_e'(instr[SRCA_LSB +: SRC_WIDTH]);
  assign src_b  = src_e'(instr[SRCB_LSB +: SRC_WIDTH]);
  assign imm    = {{(DP_WIDTH-IMM_WIDTH){instr[IMM_WIDTH-1]}}, instr[IMM_WIDTH-1:0]};

  assign op_a = pick_operand(src_a, own_i, left_i, right_i, top_i, bottom_i, imm);
  assign op_b = pick_operand(src_b, own_i, left_i, right_i, top_i, bottom_i, imm);

  // ----------------------------------------
  // ALU
  // ----------------------------------------
  // Non-ALU opcodes pass the own result through so it is kept on commit
  always_comb begin
    case (opcode)
      OP_ADD:  result_o = op_a + op_b;
      OP_SUB:  result_o = op_a - op_b;
      OP_AND:  result_o = op_a & op_b;
      OP_XOR:  result_o = op_a ^ op_b;
      default: result_o = own_i;
    endcase
  end

  // Memory and end-of-kernel decode
  assign load_o      = (opcode == OP_LOAD);
  assign store_o     = (opcode == OP_STORE);
  assign exit_o      = (opcode == OP_EXIT);
  assign mem_add_o   = op_a;
  assign mem_wdata_o = op_b;

endmodule

`default_nettype wire

// File: hw/rc_array.sv
/*
  Grid of cells with result and read-hold registers and torus wiring.
  Each column commits its result registers on its own step strobe.
*/
`timescale 1ns/1ns
`default_nettype none

module rc_array
  import cgra_pkg::*;
#(
  parameter int N_ROW    = DEF_N_ROW,
  parameter int N_COL    = DEF_N_COL,
  parameter int NUM_CREG = DEF_NUM_CREG
) (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_n_i,
  input  wire logic                                   conf_we_i,
  input  wire logic [$clog2(N_COL)-1:0]               conf_col_i,
  input  wire logic [$clog2(NUM_CREG)-1:0]            conf_addr_i,
  input  wire instr_t [N_ROW-1:0]                     conf_words_i,
  input  wire logic [N_COL-1:0][$clog2(NUM_CREG)-1:0] col_pc_i,
  input  wire logic [N_COL-1:0]                       step_i,
  input  wire logic [N_COL-1:0][N_ROW-1:0]            rd_valid_i,
  input  wire word_t [N_COL-1:0]                      data_rdata_i,
  output logic [N_COL-1:0][N_ROW-1:0]                 req_o,
  output logic [N_COL-1:0][N_ROW-1:0]                 we_o,
  output word_t [N_COL-1:0][N_ROW-1:0]                add_o,
  output word_t [N_COL-1:0][N_ROW-1:0]                wdata_o,
  output logic [N_COL-1:0]                            exit_o
);

  localparam int COL_W = $clog2(N_COL);

  word_t res_q      [N_ROW][N_COL];
  word_t hold_q     [N_ROW][N_COL];
  word_t cell_res   [N_ROW][N_COL];
  word_t cell_add   [N_ROW][N_COL];
  word_t cell_wdata [N_ROW][N_COL];
  logic  cell_load  [N_ROW][N_COL];
  logic  cell_store [N_ROW][N_COL];
  logic  cell_exit  [N_ROW][N_COL];

  // ----------------------------------------
  // Cells and torus neighbours
  // ----------------------------------------
  for (genvar r = 0; r < N_ROW; r++) begin : g_row
    for (genvar c = 0; c < N_COL; c++) begin : g_col
      localparam int R_UP = (r + N_ROW - 1) % N_ROW;
      localparam int R_DN = (r + 1) % N_ROW;
      localparam int C_LT = (c + N_COL - 1) % N_COL;
      localparam int C_RT = (c + 1) % N_COL;

      rc_cell #(
        .NUM_CREG (NUM_CREG)
      ) i_rc_cell (
        .clk_i       (clk_i),
        .conf_we_i   (conf_we_i && (conf_col_i == COL_W'(c))),
        .conf_addr_i (conf_addr_i),
        .conf_word_i (conf_words_i[r]),
        .pc_i        (col_pc_i[c]),
        .own_i       (res_q[r][c]),
        .left_i      (res_q[r][C_LT]),
        .right_i     (res_q[r][C_RT]),
        .top_i       (res_q[R_UP][c]),
        .bottom_i    (res_q[R_DN][c]),
        .result_o    (cell_res[r][c]),
        .load_o      (cell_load[r][c]),
        .store_o     (cell_store[r][c]),
        .exit_o      (cell_exit[r][c]),
        .mem_add_o   (cell_add[r][c]),
        .mem_wdata_o (cell_wdata[r][c])
      );
    end
  end

  // Regroup per column for the arbiters
  always_comb begin
    for (int c = 0; c < N_COL; c++) begin
      exit_o[c] = 1'b0;
      for (int r = 0; r < N_ROW; r++) begin
        req_o[c][r]   = cell_load[r][c] | cell_store[r][c];
        we_o[c][r]    = cell_store[r][c];
        add_o[c][r]   = cell_add[r][c];
        wdata_o[c][r] = cell_wdata[r][c];
        exit_o[c]     = exit_o[c] | cell_exit[r][c];
      end
    end
  end

  // ----------------------------------------
  // Read-hold and result registers
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    for (int r = 0; r < N_ROW; r++) begin
      for (int c = 0; c < N_COL; c++) begin
        if (rd_valid_i[c][r]) begin
          hold_q[r][c] <= data_rdata_i[c];
        end
      end
    end
  end

  // Loads take the held word, everything else the cell result
  always_ff @(posedge clk_i) begin
    for (int r = 0; r < N_ROW; r++) begin
      for (int c = 0; c < N_COL; c++) begin
        if (!rst_n_i) begin
          res_q[r][c] <= '0;
        end else if (step_i[c]) begin
          res_q[r][c] <= cell_load[r][c] ? hold_q[r][c] : cell_res[r][c];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/col_mem_arbiter.sv
/*
  Fixed-priority arbiter for one column's memory port, lowest row first.
  Read data must return in grant order, at least one cycle after grant.
*/
`timescale 1ns/1ns
`default_nettype none

module col_mem_arbiter
  import cgra_pkg::*;
#(
  parameter int N_ROW = DEF_N_ROW
) (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  input  wire logic              step_i,
  input  wire logic              active_i,
  input  wire logic [N_ROW-1:0]  req_i,
  input  wire logic [N_ROW-1:0]  we_i,
  input  wire word_t [N_ROW-1:0] add_i,
  input  wire word_t [N_ROW-1:0] wdata_i,
  input  wire logic              data_gnt_i,
  input  wire logic              data_rvalid_i,
  output logic                   data_req_o,
  output logic                   data_we_o,
  output word_t                  data_add_o,
  output word_t                  data_wdata_o,
  output logic [N_ROW-1:0]       rd_valid_o,
  output logic                   pending_o
);

  logic [N_ROW-1:0] gnt_mask_q;
  logic [N_ROW-1:0] rvalid_mask_q;
  logic [N_ROW-1:0] req_act;
  logic [N_ROW-1:0] open_req;
  logic [N_ROW-1:0] open_rd;
  logic [N_ROW-1:0] port_row;
  logic [N_ROW-1:0] rd_row;
  logic [N_ROW-1:0] gnt_sel;

  // One-hot of the lowest set bit
  function automatic logic [N_ROW-1:0] lowest_one(input logic [N_ROW-1:0] vec);
    logic [N_ROW-1:0] hot;
    logic             found;
    hot   = '0;
    found = 1'b0;
    for (int r = 0; r < N_ROW; r++) begin
      if (vec[r] && !found) begin
        hot[r] = 1'b1;
        found  = 1'b1;
      end
    end
    return hot;
  endfunction

  // ----------------------------------------
  // Request and read tracking
  // ----------------------------------------
  assign req_act  = req_i & {N_ROW{active_i}};
  assign open_req = req_act & gnt_mask_q;
  // Granted reads still waiting for their data
  assign open_rd  = req_act & ~we_i & ~gnt_mask_q & rvalid_mask_q;

  assign port_row   = lowest_one(open_req);
  assign rd_row     = lowest_one(open_rd);
  assign gnt_sel    = port_row & {N_ROW{data_gnt_i}};
  assign rd_valid_o = rd_row & {N_ROW{data_rvalid_i}};

  assign data_req_o = |open_req;
  assign pending_o  = (|open_req) | (|open_rd);

  // Port mux for the winning row
  always_comb begin
    data_we_o    = 1'b0;
    data_add_o   = '0;
    data_wdata_o = '0;
    for (int r = 0; r < N_ROW; r++) begin
      if (port_row[r]) begin
        data_we_o    = we_i[r];
        data_add_o   = add_i[r];
        data_wdata_o = wdata_i[r];
      end
    end
  end

  // ----------------------------------------
  // Masks, re-armed on every step
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || step_i) begin
      gnt_mask_q    <= '1;
      rvalid_mask_q <= '1;
    end else begin
      gnt_mask_q    <= gnt_mask_q & ~gnt_sel;
      rvalid_mask_q <= rvalid_mask_q & ~rd_valid_o;
    end
  end

endmodule

`default_nettype wire

// File: hw/col_sequencer.sv
/*
  Program counter FSM for one column. pc wraps at NUM_CREG and a kernel
  must end with OP_EXIT. start_i is ignored while the column runs.
*/
`timescale 1ns/1ns
`default_nettype none

module col_sequencer
  import cgra_pkg::*;
#(
  parameter int NUM_CREG = DEF_NUM_CREG
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,
  input  wire logic                   start_i,
  input  wire logic                   exit_i,
  input  wire logic                   pending_i,
  output logic [$clog2(NUM_CREG)-1:0] pc_o,
  output logic                        step_o,
  output logic                        active_o,
  output logic                        exec_end_o,
  output logic                        busy_o
);

  localparam int PC_W = $clog2(NUM_CREG);

  seq_state_e       state_q;
  seq_state_e       state_d;
  logic [PC_W-1:0]  pc_q;

  // ----------------------------------------
  // Next state and step strobe
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    step_o  = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (start_i) begin
          state_d = ST_RUN;
        end
      end
      ST_RUN: begin
        if (pending_i) begin
          state_d = ST_WAIT;
        end else begin
          step_o = 1'b1;
          if (exit_i) begin
            state_d = ST_IDLE;
          end
        end
      end
      ST_WAIT: begin
        // Stalled until every access of the step is served
        if (!pending_i) begin
          step_o  = 1'b1;
          state_d = exit_i ? ST_IDLE : ST_RUN;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      pc_q    <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_IDLE && start_i) begin
        pc_q <= '0;
      end else if (step_o && !exit_i) begin
        pc_q <= pc_q + 1'b1;
      end
    end
  end

  assign pc_o       = pc_q;
  assign active_o   = (state_q != ST_IDLE);
  assign busy_o     = (state_q != ST_IDLE);
  assign exec_end_o = step_o & exit_i;

endmodule

`default_nettype wire

// File: hw/cgra_top.sv
/*
  CGRA top level with one memory port per column.
  N_COL and NUM_CREG must be powers of two greater than one.
*/
`timescale 1ns/1ns
`default_nettype none

module cgra_top
  import cgra_pkg::*;
#(
  parameter int N_ROW    = DEF_N_ROW,
  parameter int N_COL    = DEF_N_COL,
  parameter int NUM_CREG = DEF_NUM_CREG
) (
  input  wire logic                        clk_i,
  input  wire logic                        rst_n_i,
  input  wire logic                        conf_we_i,
  input  wire logic [$clog2(N_COL)-1:0]    conf_col_i,
  input  wire logic [$clog2(NUM_CREG)-1:0] conf_addr_i,
  input  wire instr_t [N_ROW-1:0]          conf_words_i,
  input  wire logic [N_COL-1:0]            start_i,
  input  wire logic [N_COL-1:0]            data_gnt_i,
  input  wire logic [N_COL-1:0]            data_rvalid_i,
  input  wire word_t [N_COL-1:0]           data_rdata_i,
  output logic [N_COL-1:0]                 data_req_o,
  output logic [N_COL-1:0]                 data_we_o,
  output word_t [N_COL-1:0]                data_add_o,
  output word_t [N_COL-1:0]                data_wdata_o,
  output logic [N_COL-1:0]                 exec_end_o,
  output logic [N_COL-1:0]                 busy_o
);

  localparam int PC_W = $clog2(NUM_CREG);

  logic  [N_COL-1:0][N_ROW-1:0] req;
  logic  [N_COL-1:0][N_ROW-1:0] we;
  word_t [N_COL-1:0][N_ROW-1:0] add;
  word_t [N_COL-1:0][N_ROW-1:0] wdata;
  logic  [N_COL-1:0][N_ROW-1:0] rd_valid;
  logic  [N_COL-1:0][PC_W-1:0]  col_pc;
  logic  [N_COL-1:0]            col_exit;
  logic  [N_COL-1:0]            step;
  logic  [N_COL-1:0]            active;
  logic  [N_COL-1:0]            pending;

  rc_array #(
    .N_ROW    (N_ROW),
    .N_COL    (N_COL),
    .NUM_CREG (NUM_CREG)
  ) i_rc_array (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .conf_we_i    (conf_we_i),
    .conf_col_i   (conf_col_i),
    .conf_addr_i  (conf_addr_i),
    .conf_words_i (conf_words_i),
    .col_pc_i     (col_pc),
    .step_i       (step),
    .rd_valid_i   (rd_valid),
    .data_rdata_i (data_rdata_i),
    .req_o        (req),
    .we_o         (we),
    .add_o        (add),
    .wdata_o      (wdata),
    .exit_o       (col_exit)
  );

  // One arbiter and one sequencer per column
  for (genvar c = 0; c < N_COL; c++) begin : g_col
    col_mem_arbiter #(
      .N_ROW (N_ROW)
    ) i_col_mem_arbiter (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .step_i        (step[c]),
      .active_i      (active[c]),
      .req_i         (req[c]),
      .we_i          (we[c]),
      .add_i         (add[c]),
      .wdata_i       (wdata[c]),
      .data_gnt_i    (data_gnt_i[c]),
      .data_rvalid_i (data_rvalid_i[c]),
      .data_req_o    (data_req_o[c]),
      .data_we_o     (data_we_o[c]),
      .data_add_o    (data_add_o[c]),
      .data_wdata_o  (data_wdata_o[c]),
      .rd_valid_o    (rd_valid[c]),
      .pending_o     (pending[c])
    );

    col_sequencer #(
      .NUM_CREG (NUM_CREG)
    ) i_col_sequencer (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .start_i    (start_i[c]),
      .exit_i     (col_exit[c]),
      .pending_i  (pending[c]),
      .pc_o       (col_pc[c]),
      .step_o     (step[c]),
      .active_o   (active[c]),
      .exec_end_o (exec_end_o[c]),
      .busy_o     (busy_o[c])
    );
  end

endmodule

`default_nettype wire

// File: dv/cgra_tb_mem.sv
/*
  Word-addressed memory model for one column port, one access at a time.
  Grants after 0 to 3 waiting cycles, read data follows one cycle later.
*/
`timescale 1ns/1ns
`default_nettype none

module cgra_tb_mem
  import cgra_pkg::*;
#(
  parameter int MEM_WORDS = 256
) (
  input  wire logic  clk_i,
  input  wire logic  req_i,
  input  wire logic  we_i,
  input  wire word_t add_i,
  input  wire word_t wdata_i,
  output logic       gnt_o,
  output logic       rvalid_o,
  output word_t      rdata_o,
  output logic       acc_o,
  output word_t      acc_add_o
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  word_t       mem [MEM_WORDS];
  logic        gnt_q     = 1'b0;
  logic        rvalid_q  = 1'b0;
  word_t       rdata_q   = '0;
  logic        acc_q     = 1'b0;
  word_t       acc_add_q = '0;
  logic        lat_we;
  word_t       lat_add;
  word_t       lat_wdata;
  int unsigned wait_q    = 0;

  // ----------------------------------------
  // Port responder, updates on falling edges
  // ----------------------------------------
  always @(negedge clk_i) begin
    rvalid_q <= 1'b0;
    acc_q    <= 1'b0;
    if (gnt_q) begin
      // The rising edge in between took the grant
      gnt_q     <= 1'b0;
      wait_q    <= $urandom % 4;
      acc_q     <= 1'b1;
      acc_add_q <= lat_add;
      if (lat_we) begin
        mem[lat_add[IDX_W-1:0]] = lat_wdata;
      end else begin
        rdata_q  <= mem[lat_add[IDX_W-1:0]];
        rvalid_q <= 1'b1;
      end
    end else if (req_i) begin
      if (wait_q == 0) begin
        // Port contents hold until the next rising edge
        gnt_q     <= 1'b1;
        lat_we    <= we_i;
        lat_add   <= add_i;
        lat_wdata <= wdata_i;
      end else begin
        wait_q <= wait_q - 1;
      end
    end
  end

  assign gnt_o     = gnt_q;
  assign rvalid_o  = rvalid_q;
  assign rdata_o   = rdata_q;
  assign acc_o     = acc_q;
  assign acc_add_o = acc_add_q;

endmodule

`default_nettype wire

// File: dv/cgra_tb.sv
/*
  Directed testbench for the CGRA, one memory model per column.
  Memory helpers index the model instances directly, so N_COL is 4.
*/
`timescale 1ns/1ns
`default_nettype none

module cgra_tb
  import cgra_pkg::*;
();

  localparam int N_ROW      = DEF_N_ROW;
  localparam int N_COL      = DEF_N_COL;
  localparam int NUM_CREG   = DEF_NUM_CREG;
  localparam int COL_W      = $clog2(N_COL);
  localparam int PC_W       = $clog2(NUM_CREG);
  localparam int MEM_WORDS  = 256;
  localparam int CLK_PERIOD = 20;
  localparam int LOG_DEPTH  = 16;

  // Watchdog budget from kernel steps, program loads and run tails
  localparam int TOTAL_STEPS = 4 + 4 + 2 * 4 + 6;
  localparam int STEP_WORST  = N_ROW * 6 + 2;
  localparam int LOAD_CYC    = 5 * (N_COL * NUM_CREG + 2);
  localparam int TIMEOUT_CYC = TOTAL_STEPS * STEP_WORST + LOAD_CYC + 5 * 6 + 300;

  logic                          clk;
  logic                          rst_n;
  logic                          conf_we;
  logic [COL_W-1:0]              conf_col;
  logic [PC_W-1:0]               conf_addr;
  instr_t [N_ROW-1:0]            conf_words;
  logic [N_COL-1:0]              start;
  wire  [N_COL-1:0]              data_gnt;
  wire  [N_COL-1:0]              data_rvalid;
  wire  [N_COL-1:0][DP_WIDTH-1:0] data_rdata;
  logic [N_COL-1:0]              data_req;
  logic [N_COL-1:0]              data_we;
  word_t [N_COL-1:0]             data_add;
  word_t [N_COL-1:0]             data_wdata;
  logic [N_COL-1:0]              exec_end;
  logic [N_COL-1:0]              busy;
  wire  [N_COL-1:0]              acc;
  wire  [N_COL-1:0][DP_WIDTH-1:0] acc_add;

  int     errors;
  int     checks;
  instr_t prog    [N_COL][N_ROW][NUM_CREG];
  int     end_cnt [N_COL];
  int     end_at  [N_COL];
  int     acc_cnt [N_COL];
  word_t  acc_log [N_COL][LOG_DEPTH];
  word_t  exp_w   [N_COL][N_ROW];

  always #(CLK_PERIOD / 2) clk = ~clk;

  cgra_top #(
    .N_ROW    (N_ROW),
    .N_COL    (N_COL),
    .NUM_CREG (NUM_CREG)
  ) i_cgra_top (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .conf_we_i     (conf_we),
    .conf_col_i    (conf_col),
    .conf_addr_i   (conf_addr),
    .conf_words_i  (conf_words),
    .start_i       (start),
    .data_gnt_i    (data_gnt),
    .data_rvalid_i (data_rvalid),
    .data_rdata_i  (data_rdata),
    .data_req_o    (data_req),
    .data_we_o     (data_we),
    .data_add_o    (data_add),
    .data_wdata_o  (data_wdata),
    .exec_end_o    (exec_end),
    .busy_o        (busy)
  );

  for (genvar c = 0; c < N_COL; c++) begin : g_mem
    cgra_tb_mem #(
      .MEM_WORDS (MEM_WORDS)
    ) i_mem (
      .clk_i     (clk),
      .req_i     (data_req[c]),
      .we_i      (data_we[c]),
      .add_i     (data_add[c]),
      .wdata_i   (data_wdata[c]),
      .gnt_o     (data_gnt[c]),
      .rvalid_o  (data_rvalid[c]),
      .rdata_o   (data_rdata[c]),
      .acc_o     (acc[c]),
      .acc_add_o (acc_add[c])
    );
  end

  // ----------------------------------------
  // Reference rules and memory access
  // ----------------------------------------
  function automatic instr_t encode_instr(input opcode_e op, input src_e sa, input src_e sb,
                                          input logic [15:0] imm);
    instr_t w;
    w          = '0;
    w[31:28]   = op;
    w[27:25]   = sa;
    w[24:22]   = sb;
    w[15:0]    = imm;
    return w;
  endfunction

  function automatic word_t sign_extend(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic word_t alu_ref(input opcode_e op, input word_t a, input word_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_XOR:  return a ^ b;
      default: return '0;
    endcase
  endfunction

  // Distinct per column and per address
  function automatic word_t fill_word(input int c, input int a);
    return 32'h5a00_0000 ^ (word_t'(c) << 20) ^ (word_t'(a) * 32'h0001_0101);
  endfunction

  function automatic logic [15:0] torus_val(input int r, input int c);
    return 16'h0100 * 16'(r + 1) + 16'h0011 * 16'(c) + 16'h0003;
  endfunction

  function automatic word_t peek_mem(input int c, input int a);
    case (c)
      0:       return g_mem[0].i_mem.mem[a];
      1:       return g_mem[1].i_mem.mem[a];
      2:       return g_mem[2].i_mem.mem[a];
      default: return g_mem[3].i_mem.mem[a];
    endcase
  endfunction

  task automatic poke_mem(input int c, input int a, input word_t v);
    case (c)
      0:       g_mem[0].i_mem.mem[a] = v;
      1:       g_mem[1].i_mem.mem[a] = v;
      2:       g_mem[2].i_mem.mem[a] = v;
      default: g_mem[3].i_mem.mem[a] = v;
    endcase
  endtask

  task automatic fill_memories();
    for (int c = 0; c < N_COL; c++) begin
      for (int a = 0; a < MEM_WORDS; a++) begin
        poke_mem(c, a, fill_word(c, a));
      end
    end
  endtask

  task automatic expect_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  // ----------------------------------------
  // Configuration and kernel runs
  // ----------------------------------------
  task automatic clear_prog();
    for (int c = 0; c < N_COL; c++) begin
      for (int r = 0; r < N_ROW; r++) begin
        for (int a = 0; a < NUM_CREG; a++) begin
          prog[c][r][a] = encode_instr(OP_NOP, SRC_ZERO, SRC_ZERO, 16'h0);
        end
      end
    end
  endtask

  task automatic load_prog();
    for (int c = 0; c < N_COL; c++) begin
      for (int a = 0; a < NUM_CREG; a++) begin
        @(negedge clk);
        conf_we   = 1'b1;
        conf_col  = COL_W'(c);
        conf_addr = PC_W'(a);
        for (int r = 0; r < N_ROW; r++) begin
          conf_words[r] = prog[c][r][a];
        end
      end
    end
    @(negedge clk);
    conf_we = 1'b0;
  endtask

  // Starts the masked columns, logs port accesses and end pulses per column
  task automatic run_kernel(input logic [N_COL-1:0] mask, input logic [N_COL-1:0] restart_mask,
                            input int restart_at);
    logic [N_COL-1:0] seen;
    int               n;
    int               tail;
    seen = '0;
    n    = 0;
    tail = 0;
    for (int c = 0; c < N_COL; c++) begin
      end_cnt[c] = 0;
      end_at[c]  = -1;
      acc_cnt[c] = 0;
    end
    @(negedge clk);
    start = mask;
    while (tail < 4) begin
      @(negedge clk);
      n++;
      start = (n == restart_at) ? restart_mask : '0;
      for (int c = 0; c < N_COL; c++) begin
        if (seen[c]) begin
          expect_word($sformatf("busy_o[%0d]", c), word_t'(busy[c]), '0);
        end else if (mask[c] && !busy[c]) begin
          errors++;
          $display("Column %0d went idle before its exec_end_o pulse", c);
        end
        if (exec_end[c]) begin
          end_cnt[c]++;
          end_at[c] = n;
          seen[c]   = 1'b1;
        end
        if (acc[c]) begin
          if (acc_cnt[c] < LOG_DEPTH) begin
            acc_log[c][acc_cnt[c]] = acc_add[c];
          end
          acc_cnt[c]++;
        end
      end
      if ((seen & mask) == mask) begin
        tail++;
      end
    end
    for (int c = 0; c < N_COL; c++) begin
      expect_word($sformatf("exec_end_o[%0d] pulses", c), word_t'(end_cnt[c]),
                  word_t'(mask[c]));
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic check_reset_idle();
    repeat (8) begin
      @(negedge clk);
      expect_word("data_req_o", word_t'(data_req), '0);
      expect_word("data_we_o", word_t'(data_we), '0);
      expect_word("exec_end_o", word_t'(exec_end), '0);
      expect_word("busy_o", word_t'(busy), '0);
    end
  endtask

  task automatic check_alu_kernel();
    opcode_e     ops [N_COL];
    logic [15:0] a;
    logic [15:0] b;
    ops[0] = OP_ADD;
    ops[1] = OP_SUB;
    ops[2] = OP_AND;
    ops[3] = OP_XOR;
    clear_prog();
    for (int c = 0; c < N_COL; c++) begin
      for (int r = 0; r < N_ROW; r++) begin
        a = 16'($urandom);
        b = 16'($urandom);
        prog[c][r][0] = encode_instr(OP_ADD, SRC_ZERO, SRC_IMM, a);
        prog[c][r][1] = encode_instr(ops[c], SRC_OWN, SRC_IMM, b);
        prog[c][r][2] = encode_instr(OP_STORE, SRC_IMM, SRC_OWN, 16'(16 + r));
        prog[c][r][3] = encode_instr(OP_EXIT, SRC_ZERO, SRC_ZERO, 16'h0);
        exp_w[c][r]   = alu_ref(ops[c], sign_extend(a), sign_extend(b));
      end
    end
    load_prog();
    run_kernel('1, '0, 0);
    for (int c = 0; c < N_COL; c++) begin
      for (int r = 0; r < N_ROW; r++) begin
        expect_word($sformatf("mem%0d[0x%02h]", c, 16 + r), peek_mem(c, 16 + r), exp_w[c][r]);
      end
    end
  endtask

  task automatic check_torus_wrap();
    word_t exp;
    clear_prog();
    for (int c = 0; c < N_COL; c++) begin
      for (int r = 0; r < N_ROW; r++) begin
        prog[c][r][0] = encode_instr(OP_ADD, SRC_ZERO, SRC_IMM, torus_val(r, c));
        prog[c][r][1] = encode_instr(OP_ADD, SRC_LEFT, SRC_TOP, 16'h0);
        prog[c][r][2] = encode_instr(OP_STORE, SRC_IMM, SRC_OWN, 16'(32 + r));
        prog[c][r][3] = encode_instr(OP_EXIT, SRC_ZERO, SRC_ZERO, 16'h0);
      end
    end
    load_prog();
    run_kernel('1, '0, 0);
    for (int c = 0; c < N_COL; c++) begin
      for (int r = 0; r < N_ROW; r++) begin
        // Left is column c-1 and top is row r-1, both wrapping
        exp = sign_extend(torus_val(r, (c + N_COL - 1) % N_COL)) +
              sign_extend(torus_val((r + N_ROW - 1) % N_ROW, c));
        expect_word($sformatf("mem%0d[0x%02h]", c, 32 + r), peek_mem(c, 32 + r), exp);
      end
    end
  endtask

  task automatic check_contention(input int rounds);
    logic [15:0] k;
    for (int rnd = 0; rnd < rounds; rnd++) begin
      fill_memories();
      clear_prog();
      k = 16'($urandom);
      for (int c = 0; c < N_COL; c++) begin
        for (int r = 0; r < N_ROW; r++) begin
          prog[c][r][0] = encode_instr(OP_LOAD, SRC_IMM, SRC_ZERO, 16'(64 + 5 * r));
          prog[c][r][1] = encode_instr(OP_ADD, SRC_OWN, SRC_IMM, k);
          prog[c][r][2] = encode_instr(OP_STORE, SRC_IMM, SRC_OWN, 16'(96 + r));
          prog[c][r][3] = encode_instr(OP_EXIT, SRC_ZERO, SRC_ZERO, 16'h0);
        end
      end
      load_prog();
      run_kernel('1, '0, 0);
      for (int c = 0; c < N_COL; c++) begin
        expect_word($sformatf("port %0d access count", c), word_t'(acc_cnt[c]),
                    word_t'(2 * N_ROW));
        for (int r = 0; r < N_ROW; r++) begin
          expect_word($sformatf("mem%0d[0x%02h]", c, 96 + r), peek_mem(c, 96 + r),
                      fill_word(c, 64 + 5 * r) + sign_extend(k));
          // Loads of all rows first, then the stores, lowest row first
          if (acc_cnt[c] == 2 * N_ROW) begin
            expect_word($sformatf("data_add_o[%0d] load #%0d", c, r), acc_log[c][r],
                        word_t'(64 + 5 * r));
            expect_word($sformatf("data_add_o[%0d] store #%0d", c, r), acc_log[c][N_ROW + r],
                        word_t'(96 + r));
          end
        end
      end
    end
  endtask

  task automatic check_kernel_end();
    clear_prog();
    for (int p = 0; p < 5; p++) begin
      prog[0][0][p] = encode_instr(OP_ADD, SRC_OWN, SRC_IMM, 16'h0001);
    end
    prog[0][0][5] = encode_instr(OP_EXIT, SRC_ZERO, SRC_ZERO, 16'h0);
    prog[1][0][0] = encode_instr(OP_EXIT, SRC_ZERO, SRC_ZERO, 16'h0);
    prog[2][0][0] = encode_instr(OP_ADD, SRC_ZERO, SRC_IMM, 16'h0021);
    prog[2][0][1] = encode_instr(OP_STORE, SRC_IMM, SRC_OWN, 16'h0080);
    prog[2][0][2] = encode_instr(OP_EXIT, SRC_ZERO, SRC_ZERO, 16'h0);
    prog[3][0][0] = encode_instr(OP_ADD, SRC_ZERO, SRC_IMM, 16'h0030);
    prog[3][0][1] = encode_instr(OP_ADD, SRC_OWN, SRC_IMM, 16'h0005);
    prog[3][0][2] = encode_instr(OP_STORE, SRC_IMM, SRC_OWN, 16'h0080);
    prog[3][0][3] = encode_instr(OP_EXIT, SRC_ZERO, SRC_ZERO, 16'h0);
    load_prog();
    // Second start on column 0 while it is still running
    run_kernel('1, N_COL'(1), 2);
    expect_word("exec_end_o[0] cycle", word_t'(end_at[0]), 32'd6);
    expect_word("exec_end_o[1] cycle", word_t'(end_at[1]), 32'd1);
    expect_word("mem2[0x80]", peek_mem(2, 8'h80), 32'h0000_0021);
    expect_word("mem3[0x80]", peek_mem(3, 8'h80), 32'h0000_0035);
  endtask

  // ----------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------
  initial begin
    int unsigned seed;
    seed = 32'h4b89;
    void'($urandom(seed));
    errors     = 0;
    checks     = 0;
    clk        = 1'b0;
    rst_n      = 1'b0;
    conf_we    = 1'b0;
    conf_col   = '0;
    conf_addr  = '0;
    conf_words = '0;
    start      = '0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    fill_memories();

    check_reset_idle();
    check_alu_kernel();
    check_torus_wrap();
    check_contention(2);
    check_kernel_end();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_CYC * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles with a kernel still running, errors: %0d",
             TIMEOUT_CYC, errors);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
hw/cgra_pkg.sv
hw/rc_cell.sv
hw/rc_array.sv
hw/col_mem_arbiter.sv
hw/col_sequencer.sv
hw/cgra_top.sv
dv/cgra_tb_mem.sv
dv/cgra_tb.sv
